// File: source/ex_pkg.sv
// Execute stage shared definitions

package ex_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int XLEN       = 32;  // Data word width
    localparam int REG_ADDR_W = 5;   // GPR address width
    localparam int SHAMT_W    = 5;   // Shift amount, low bits of operand 1
    localparam int EXP_CODE_W = 3;   // Exception code width

    //////////////////////////////////////////////////
    // Operation encodings
    //////////////////////////////////////////////////

    // RV32I register-register ALU ops
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Branch conditions, NOP means no branch
    typedef enum logic [2:0] {
        CMP_NOP = 3'd0,
        CMP_EQ  = 3'd1,
        CMP_NE  = 3'd2,
        CMP_LT  = 3'd3,
        CMP_GE  = 3'd4,
        CMP_LTU = 3'd5,
        CMP_GEU = 3'd6
    } cmp_op_e;

    // Memory access type, carried to MEM
    typedef enum logic [2:0] {
        MEM_NOP = 3'd0,
        MEM_LW  = 3'd1,
        MEM_LH  = 3'd2,
        MEM_LB  = 3'd3,
        MEM_SW  = 3'd4
    } mem_op_e;

    // Write-back value source
    typedef enum logic [1:0] {
        SEL_ALU  = 2'd0,  // ALU result
        SEL_CMP  = 2'd1,  // Condition flag, zero-extended
        SEL_LINK = 2'd2   // Return address pc + 4
    } out_sel_e;

    typedef logic [EXP_CODE_W-1:0] exp_code_t;  // Passed through untouched

    localparam exp_code_t EXP_NONE = '0;  // No exception

    //////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;        // Real instruction
        logic [XLEN-1:0]       pc;           // Instruction address
        alu_op_e               alu_op;
        logic [XLEN-1:0]       alu_in_0;
        logic [XLEN-1:0]       alu_in_1;
        cmp_op_e               cmp_op;
        logic [XLEN-1:0]       cmp_in_0;
        logic [XLEN-1:0]       cmp_in_1;
        logic                  jump_taken;   // Unconditional jump
        logic                  is_jalr;      // Target bit 0 cleared
        mem_op_e               mem_op;
        logic [XLEN-1:0]       mem_wr_data;  // Store data
        logic [REG_ADDR_W-1:0] rd_addr;      // Destination register
        logic                  gpr_we;       // GPR write enable
        out_sel_e              out_sel;
        exp_code_t             exp_code;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       result;       // Write-back or address value
        mem_op_e               mem_op;
        logic [XLEN-1:0]       mem_wr_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  gpr_we;
        exp_code_t             exp_code;
    } ex_mem_t;

    // Empty slot in ID/EX
    localparam id_ex_t ID_EX_BUBBLE = '{
        valid:       1'b0,
        pc:          '0,
        alu_op:      ALU_ADD,
        alu_in_0:    '0,
        alu_in_1:    '0,
        cmp_op:      CMP_NOP,  // Keeps redirect low
        cmp_in_0:    '0,
        cmp_in_1:    '0,
        jump_taken:  1'b0,
        is_jalr:     1'b0,
        mem_op:      MEM_NOP,
        mem_wr_data: '0,
        rd_addr:     '0,
        gpr_we:      1'b0,
        out_sel:     SEL_ALU,
        exp_code:    EXP_NONE
    };

    // Empty slot in EX/MEM
    localparam ex_mem_t EX_MEM_BUBBLE = '{
        valid:       1'b0,
        result:      '0,
        mem_op:      MEM_NOP,
        mem_wr_data: '0,
        rd_addr:     '0,
        gpr_we:      1'b0,
        exp_code:    EXP_NONE
    };

endpackage

// File: source/stage_reg.sv
// Pipeline stage register
`timescale 1ns/10ps

module stage_reg #(
    parameter type      payload_t   = logic [31:0],  // Carried payload
    parameter payload_t RESET_VALUE = '0             // Reset and bubble value
) (
    input  logic     clk,     // Core clock
    input  logic     arst_n,  // Async reset, active low
    input  logic     stall,   // Freeze stage
    input  logic     flush,   // Insert bubble
    input  payload_t d,       // Next payload
    output payload_t q        // Registered payload
);

    //////////////////////////////////////////////////
    // Next value
    //////////////////////////////////////////////////

    payload_t load_val;  // Value taken on an unstalled edge

    always_comb begin
        if (flush) begin
            load_val = RESET_VALUE;  // Squash incoming item
        end else begin
            load_val = d;
        end
    end

    //////////////////////////////////////////////////
    // Register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= RESET_VALUE;  // Start empty
        end else if (!stall) begin
            q <= load_val;
        end
        // Stall keeps q as is
    end

endmodule

// File: source/alu_unit.sv
// Integer ALU
`timescale 1ns/10ps

module alu_unit (
    input  ex_pkg::alu_op_e         op,      // Operation
    input  logic [ex_pkg::XLEN-1:0] in_0,    // Operand 0, rs1 or pc
    input  logic [ex_pkg::XLEN-1:0] in_1,    // Operand 1, rs2 or imm
    output logic [ex_pkg::XLEN-1:0] result   // Combinational result
);
    import ex_pkg::*;

    //////////////////////////////////////////////////
    // Shared adder
    //////////////////////////////////////////////////

    logic            is_sub;    // Subtract select
    logic [XLEN-1:0] add_b;     // Second adder input
    logic [XLEN-1:0] sum;       // in_0 +/- in_1
    logic [SHAMT_W-1:0] shamt;  // Low five bits of in_1
    logic            lt_s;      // Signed less-than
    logic            lt_u;      // Unsigned less-than

    assign is_sub = (op == ALU_SUB);
    assign add_b  = is_sub ? ~in_1 : in_1;              // Two's complement
    assign sum    = in_0 + add_b + XLEN'(is_sub);        // Carry in on SUB

    assign shamt  = in_1[SHAMT_W-1:0];

    assign lt_s   = ($signed(in_0) < $signed(in_1));
    assign lt_u   = (in_0 < in_1);

    //////////////////////////////////////////////////
    // Result mux
    //////////////////////////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_SUB: begin
                result = sum;
            end
            ALU_AND: begin
                result = in_0 & in_1;
            end
            ALU_OR: begin
                result = in_0 | in_1;
            end
            ALU_XOR: begin
                result = in_0 ^ in_1;
            end
            ALU_SLL: begin
                result = in_0 << shamt;
            end
            ALU_SRL: begin
                result = in_0 >> shamt;               // Zero fill
            end
            ALU_SRA: begin
                result = $signed(in_0) >>> shamt;     // Sign fill
            end
            ALU_SLT: begin
                result = XLEN'(lt_s);                 // 1 or 0
            end
            ALU_SLTU: begin
                result = XLEN'(lt_u);
            end
            default: begin
                result = '0;                          // Unused encodings
            end
        endcase
    end

endmodule

// File: source/cmp_unit.sv
// Branch condition comparator
`timescale 1ns/10ps

module cmp_unit (
    input  ex_pkg::cmp_op_e         op,         // Branch condition
    input  logic [ex_pkg::XLEN-1:0] in_0,       // rs1 value
    input  logic [ex_pkg::XLEN-1:0] in_1,       // rs2 value
    output logic                    cond_true   // Condition holds
);
    import ex_pkg::*;

    //////////////////////////////////////////////////
    // Shared subtractor
    //////////////////////////////////////////////////

    logic [XLEN:0] diff;  // Extra bit catches the borrow
    logic          eq;    // Operands equal
    logic          lt_u;  // Unsigned less-than
    logic          lt_s;  // Signed less-than

    assign diff = {1'b0, in_0} - {1'b0, in_1};
    assign eq   = (diff[XLEN-1:0] == '0);         // Zero difference
    assign lt_u = diff[XLEN];                     // Borrow out

    // Same signs follow the unsigned answer, different signs follow in_0
    assign lt_s = (in_0[XLEN-1] != in_1[XLEN-1]) ? in_0[XLEN-1] : lt_u;

    //////////////////////////////////////////////////
    // Condition select
    //////////////////////////////////////////////////

    always_comb begin
        case (op)
            CMP_EQ:  cond_true = eq;
            CMP_NE:  cond_true = !eq;
            CMP_LT:  cond_true = lt_s;
            CMP_GE:  cond_true = !lt_s;
            CMP_LTU: cond_true = lt_u;
            CMP_GEU: cond_true = !lt_u;
            default: cond_true = 1'b0;            // CMP_NOP means no branch
        endcase
    end

endmodule

// File: source/ex_combine.sv
// Execute result combiner
`timescale 1ns/10ps

module ex_combine (
    input  ex_pkg::id_ex_t          id_ex,        // Current EX instruction
    input  logic [ex_pkg::XLEN-1:0] alu_result,   // From ALU
    input  logic                    cond_true,    // From comparator
    output ex_pkg::ex_mem_t         ex_next,      // Into EX/MEM register
    output logic                    redirect,     // Fetch redirect request
    output logic [ex_pkg::XLEN-1:0] redirect_pc   // Redirect target
);
    import ex_pkg::*;

    //////////////////////////////////////////////////
    // Write-back value
    //////////////////////////////////////////////////

    logic [XLEN-1:0] link_addr;  // Return address
    logic [XLEN-1:0] cmp_word;   // Flag as a full word
    logic [XLEN-1:0] result;     // Selected value

    assign link_addr = id_ex.pc + XLEN'(4);
    assign cmp_word  = XLEN'(cond_true);  // Zero-extended

    always_comb begin
        case (id_ex.out_sel)
            SEL_ALU:  result = alu_result;
            SEL_CMP:  result = cmp_word;
            SEL_LINK: result = link_addr;   // JAL and JALR
            default:  result = alu_result;
        endcase
    end

    //////////////////////////////////////////////////
    // EX/MEM payload
    //////////////////////////////////////////////////

    always_comb begin
        ex_next             = EX_MEM_BUBBLE;
        ex_next.valid       = id_ex.valid;
        ex_next.result      = result;                     // Also load/store address
        ex_next.mem_op      = id_ex.mem_op;
        ex_next.mem_wr_data = id_ex.mem_wr_data;          // Store data
        ex_next.rd_addr     = id_ex.rd_addr;
        ex_next.gpr_we      = id_ex.valid & id_ex.gpr_we; // No write from bubbles
        ex_next.exp_code    = id_ex.exp_code;             // Pass through
    end

    //////////////////////////////////////////////////
    // Redirect
    //////////////////////////////////////////////////

    logic take;  // Jump or branch taken

    assign take     = id_ex.jump_taken | cond_true;
    assign redirect = id_ex.valid & take;

    // ALU computes the target, JALR drops bit 0
    assign redirect_pc = {alu_result[XLEN-1:1], alu_result[0] & ~id_ex.is_jalr};

endmodule

// File: source/ex_stage_top.sv
// Execute stage top level
`timescale 1ns/10ps

module ex_stage_top (
    input  logic                    clk,          // Core clock
    input  logic                    arst_n,       // Async reset, active low
    input  ex_pkg::id_ex_t          id_in,        // Decoded instruction
    input  logic                    stall,        // Freeze both registers
    input  logic                    flush,        // Bubble into ID/EX
    output ex_pkg::ex_mem_t         ex_out,       // To memory stage
    output logic                    redirect,     // Taken jump or branch
    output logic [ex_pkg::XLEN-1:0] redirect_pc   // Target address
);
    import ex_pkg::*;

    id_ex_t          id_ex;       // ID/EX register output
    logic [XLEN-1:0] alu_result;  // ALU output
    logic            cond_true;   // Comparator output
    ex_mem_t         ex_next;     // Combined EX result

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////

    stage_reg #(
        .payload_t   (id_ex_t),
        .RESET_VALUE (ID_EX_BUBBLE)
    ) i_id_ex_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall),
        .flush  (flush),
        .d      (id_in),
        .q      (id_ex)
    );

    //////////////////////////////////////////////////
    // Parallel units
    //////////////////////////////////////////////////

    alu_unit i_alu (
        .op     (id_ex.alu_op),
        .in_0   (id_ex.alu_in_0),
        .in_1   (id_ex.alu_in_1),
        .result (alu_result)
    );

    cmp_unit i_cmp (
        .op        (id_ex.cmp_op),
        .in_0      (id_ex.cmp_in_0),
        .in_1      (id_ex.cmp_in_1),
        .cond_true (cond_true)
    );

    ex_combine i_combine (
        .id_ex       (id_ex),
        .alu_result  (alu_result),
        .cond_true   (cond_true),
        .ex_next     (ex_next),
        .redirect    (redirect),      // Straight out, not registered
        .redirect_pc (redirect_pc)
    );

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////

    stage_reg #(
        .payload_t   (ex_mem_t),
        .RESET_VALUE (EX_MEM_BUBBLE)
    ) i_ex_mem_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall),
        .flush  (1'b0),               // Flush acts on ID/EX only
        .d      (ex_next),
        .q      (ex_out)
    );

endmodule

// File: tb/ex_model.svh
// Execute stage reference model
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

//////////////////////////////////////////////////
// Prediction record
//////////////////////////////////////////////////

typedef struct packed {
    ex_mem_t         ex;        // Expected EX/MEM payload
    logic            redirect;  // Expected redirect
    logic [XLEN-1:0] target;    // Expected redirect_pc
} pred_t;

//////////////////////////////////////////////////
// ALU and branch condition
//////////////////////////////////////////////////

function automatic logic [XLEN-1:0] model_alu(input alu_op_e         op,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [4:0]      sh;    // Shift amount from low five bits
    logic [XLEN-1:0] fill;  // Sign bits shifted in by SRA
    logic [XLEN-1:0] res;
    sh   = b[4:0];
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    case (op)
        ALU_ADD:  res = a + b;
        ALU_SUB:  res = a - b;
        ALU_AND:  res = a & b;
        ALU_OR:   res = a | b;
        ALU_XOR:  res = a ^ b;
        ALU_SLL:  res = a << sh;
        ALU_SRL:  res = a >> sh;
        ALU_SRA:  res = (a >> sh) | fill;
        ALU_SLT:  res = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
        ALU_SLTU: res = {{(XLEN-1){1'b0}}, (a < b)};
        default:  res = '0;
    endcase
    return res;
endfunction

function automatic logic model_cond(input cmp_op_e         op,
                                    input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
    logic lt_s;
    logic lt_u;
    logic res;
    lt_s = ($signed(a) < $signed(b));
    lt_u = (a < b);
    case (op)
        CMP_EQ:  res = (a == b);
        CMP_NE:  res = (a != b);
        CMP_LT:  res = lt_s;
        CMP_GE:  res = !lt_s;
        CMP_LTU: res = lt_u;
        CMP_GEU: res = !lt_u;
        default: res = 1'b0;  // No branch
    endcase
    return res;
endfunction

//////////////////////////////////////////////////
// Whole stage
//////////////////////////////////////////////////

function automatic pred_t predict(input id_ex_t item);
    pred_t           p;
    logic [XLEN-1:0] alu;
    logic            cond;
    alu  = model_alu(item.alu_op, item.alu_in_0, item.alu_in_1);
    cond = model_cond(item.cmp_op, item.cmp_in_0, item.cmp_in_1);
    case (item.out_sel)
        SEL_CMP:  p.ex.result = {{(XLEN-1){1'b0}}, cond};  // Flag as word
        SEL_LINK: p.ex.result = item.pc + XLEN'(4);         // Return address
        default:  p.ex.result = alu;
    endcase
    p.ex.valid       = item.valid;
    p.ex.mem_op      = item.mem_op;
    p.ex.mem_wr_data = item.mem_wr_data;
    p.ex.rd_addr     = item.rd_addr;
    p.ex.gpr_we      = item.valid && item.gpr_we;  // Bubbles never write
    p.ex.exp_code    = item.exp_code;
    p.redirect       = item.valid && (item.jump_taken || cond);
    p.target         = item.is_jalr ? (alu & ~XLEN'(1)) : alu;  // JALR clears bit 0
    return p;
endfunction

`endif

// File: tb/tb_ex_stage.sv
// Execute stage testbench
`timescale 1ns/10ps

module tb_ex_stage;
    import ex_pkg::*;

    `include "ex_model.svh"

    localparam int          CLK_PERIOD     = 20;               // ns
    localparam int          RESET_CYCLES   = 5;
    localparam int          NUM_VEC        = 400;              // Accepted inputs
    localparam int          TIMEOUT_CYCLES = NUM_VEC * 4 + 100;
    localparam logic [31:0] LFSR_SEED      = 32'd87;

    logic            clk;
    logic            arst_n;
    id_ex_t          id_in;
    logic            stall;
    logic            flush;
    ex_mem_t         ex_out;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    pred_t       pred_q[$];               // Item held in ID/EX at the front
    ex_mem_t     exp_out;                 // Expected EX/MEM contents
    int          n_accepted  = 0;         // Unstalled edges
    logic [31:0] lfsr_state  = LFSR_SEED;

    ex_stage_top i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_in       (id_in),
        .stall       (stall),
        .flush       (flush),
        .ex_out      (ex_out),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    //////////////////////////////////////////////////
    // Clock and watchdog
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout: the stimulus did not finish before the watchdog limit");
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            value      = {value[30:0], lfsr_state[31]};  // Take the bit shifted out
            lfsr_state = {lfsr_state[30:0], fb};
        end
        return value;
    endfunction

    function automatic id_ex_t random_instr();
        id_ex_t item;
        item.valid       = (rand_bits(3) != 32'd0);                 // Mostly real
        item.pc          = rand_bits(30) << 2;                      // Word aligned
        item.alu_op      = alu_op_e'(4'(rand_bits(4) % 32'd10));
        item.alu_in_0    = rand_bits(XLEN);
        item.alu_in_1    = (rand_bits(3) == 32'd0) ? item.alu_in_0 : rand_bits(XLEN);
        item.cmp_op      = cmp_op_e'(3'(rand_bits(3) % 32'd7));
        item.cmp_in_0    = rand_bits(XLEN);
        item.cmp_in_1    = (rand_bits(2) == 32'd0) ? item.cmp_in_0 : rand_bits(XLEN);
        item.jump_taken  = (rand_bits(3) == 32'd0);
        item.is_jalr     = (rand_bits(2) == 32'd0);
        item.mem_op      = mem_op_e'(3'(rand_bits(3) % 32'd5));
        item.mem_wr_data = rand_bits(XLEN);
        item.rd_addr     = REG_ADDR_W'(rand_bits(REG_ADDR_W));
        item.gpr_we      = (rand_bits(1) != 32'd0);
        item.out_sel     = out_sel_e'(2'(rand_bits(2) % 32'd3));
        item.exp_code    = exp_code_t'(rand_bits(3));
        return item;
    endfunction

    // New instruction only after the last one was taken
    task automatic drive_inputs(input logic take_new);
        stall = (rand_bits(2) == 32'd0);  // About 25 percent
        flush = (rand_bits(3) == 32'd0);
        if (take_new) begin
            id_in = random_instr();
        end
    endtask

    //////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Applies the edge that just passed, with the inputs still on the bus
    task automatic step_model();
        id_ex_t item;
        pred_t  gone;
        if (!stall) begin
            item = flush ? ID_EX_BUBBLE : id_in;  // Flush squashes the input
            pred_q.push_back(predict(item));
            gone    = pred_q.pop_front();         // Moves on into EX/MEM
            exp_out = gone.ex;
            n_accepted++;
        end
    endtask

    task automatic check_outputs();
        check_value("redirect", 64'(redirect), 64'(pred_q[0].redirect));
        check_value("redirect_pc", 64'(redirect_pc), 64'(pred_q[0].target));
        check_value("ex_out.valid", 64'(ex_out.valid), 64'(exp_out.valid));
        check_value("ex_out.result", 64'(ex_out.result), 64'(exp_out.result));
        check_value("ex_out.mem_op", 64'(ex_out.mem_op), 64'(exp_out.mem_op));
        check_value("ex_out.mem_wr_data", 64'(ex_out.mem_wr_data), 64'(exp_out.mem_wr_data));
        check_value("ex_out.rd_addr", 64'(ex_out.rd_addr), 64'(exp_out.rd_addr));
        check_value("ex_out.gpr_we", 64'(ex_out.gpr_we), 64'(exp_out.gpr_we));
        check_value("ex_out.exp_code", 64'(ex_out.exp_code), 64'(exp_out.exp_code));
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic take_new;
        id_in  = ID_EX_BUBBLE;
        stall  = 1'b0;
        flush  = 1'b0;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Empty pipeline straight out of reset
        check_value("ex_out.valid", 64'(ex_out.valid), 64'(1'b0));
        check_value("ex_out.gpr_we", 64'(ex_out.gpr_we), 64'(1'b0));
        check_value("ex_out.mem_op", 64'(ex_out.mem_op), 64'(MEM_NOP));
        check_value("redirect", 64'(redirect), 64'(1'b0));

        pred_q.push_back(predict(ID_EX_BUBBLE));
        exp_out = EX_MEM_BUBBLE;
        drive_inputs(1'b1);

        while (n_accepted < NUM_VEC) begin
            @(negedge clk);
            take_new = !stall;               // Held while stalled
            step_model();
            check_outputs();
            drive_inputs(take_new);
        end

        // Drain both registers with bubbles
        repeat (3) begin
            @(negedge clk);
            step_model();
            check_outputs();
            stall = 1'b0;
            flush = 1'b0;
            id_in = ID_EX_BUBBLE;
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: build.f
+incdir+tb
source/ex_pkg.sv
source/stage_reg.sv
source/alu_unit.sv
source/cmp_unit.sv
source/ex_combine.sv
source/ex_stage_top.sv
tb/tb_ex_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when the test fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f build.f \
    --top-module tb_ex_stage \
    --Mdir obj_dir \
    -o sim_ex_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_ex_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
